// File: Bender.yml
package:
  name: spi_soc

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - common/dbg_pkg.sv
      - debug/spi_slave.sv
      - debug/dbg_controller.sv
      - debug/core_clock_ctrl.sv
      - core/step_core.sv
      - design/spi_soc.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_spi_soc.sv

// File: bench/spi_soc_patterns.txt
# columns: test name, MOSI byte (hex), expected MISO byte of the same transfer (hex, -- don't care)
# MISO of each transfer is the answer to the byte before it
echo 01 00
echo 5A 01
echo 00 5A
echo 01 00
echo A5 01
echo 00 A5
echo 01 00
echo FF 01
echo 00 FF
echo CC 00
echo 00 CC
echo 08 00
echo 00 FF
echo 77 00
echo 00 FF
echo 0A 00
echo 00 FF
echo 00 00
led 02 00
led 02 00
led 00 00
led 02 00
led 02 00
led 00 00

// File: bench/tb_spi_soc.sv
`timescale 1ns/10ps
`include "soc_settings.svh"

module tb_spi_soc;

    logic clk;
    logic rst;
    logic sclk;
    logic mosi;
    logic ss;
    logic miso;
    logic led;

    int errors;
    int checks;
    int tests;
    logic [31:0] rng_state;

    spi_soc u_dut (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .ss   (ss),
        .miso (miso),
        .led  (led)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // one SPI mode-0 byte of 5-clk half periods sent MSB first
    task automatic xfer(input logic [7:0] tx, output logic [7:0] rx);
        int wait_cnt;
        ss = 1'b0;
        tick(4);
        for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            tick(5);
            rx[i] = miso;
            sclk = 1'b1;
            if (i > 0) begin
                tick(5);
                sclk = 1'b0;
            end
        end
        wait_cnt = 0;
        while (!u_dut.recv_ready && wait_cnt < 20) begin
            tick(1);
            wait_cnt++;
        end
        if (!u_dut.recv_ready) begin
            $display("timeout: the DUT never signalled a received byte");
            errors++;
        end
        tick(5);
        sclk = 1'b0;
        tick(2);
        ss = 1'b1;
        tick(8);
    endtask

    // n NOP transfers with the reply bytes collected MSB first
    task automatic read_reply(input int n, output logic [63:0] val);
        logic [7:0] b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            xfer(8'h00, b);
            val = (val << 8) | 64'(b);
        end
    endtask

    task automatic get_pc(output logic [31:0] p);
        logic [7:0]  b;
        logic [63:0] v;
        xfer(8'h06, b);
        read_reply(4, v);
        p = v[31:0];
    endtask

    task automatic run_patterns();
        int          fd;
        int          err_before;
        logic        led_exp;
        logic [7:0]  tx;
        logic [7:0]  exp;
        logic [7:0]  rx;
        string       line;
        string       tname;
        string       exp_s;
        string       cur;
        fd = $fopen("bench/spi_soc_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file bench/spi_soc_patterns.txt");
            errors++;
        end else begin
            led_exp = 1'b0;
            cur = "";
            err_before = errors;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%s %h %s", tname, tx, exp_s) == 3) begin
                    if (tname != cur) begin
                        if (cur != "") begin
                            finish_test(cur, err_before);
                        end
                        cur = tname;
                        err_before = errors;
                    end
                    xfer(tx, rx);
                    if (exp_s != "--") begin
                        void'($sscanf(exp_s, "%h", exp));
                        check_value("miso", 64'(exp), 64'(rx));
                    end
                    if (tname == "led") begin
                        if (tx == 8'h02) begin
                            led_exp = ~led_exp;
                        end
                        check_value("led", 64'(led_exp), 64'(led));
                    end
                end
            end
            if (cur != "") begin
                finish_test(cur, err_before);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic [7:0]  b;
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] pc_now;
        logic [31:0] base;
        logic [31:0] old;
        logic [31:0] prev;
        logic [31:0] a;
        logic [31:0] c;
        logic [63:0] v;
        logic [4:0]  idx;
        int          steps;
        int          pick;
        int          err0;

        clk = 1'b0;
        rst = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        ss = 1'b1;
        errors = 0;
        checks = 0;
        tests = 0;
        rng_state = 32'd2;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        tick(4);

        run_patterns();

        // halt the core and one step must add exactly 4
        err0 = errors;
        xfer(8'h04, b);
        get_pc(p1);
        get_pc(p2);
        check_value("pc", 64'(p1), 64'(p2));
        xfer(8'h05, b);
        get_pc(pc_now);
        check_value("pc", 64'(p1 + 32'd4), 64'(pc_now));
        finish_test("halted_pc", err0);

        // each step writes the old pc into register (pc/4 mod 32)
        err0 = errors;
        rng_state = xorshift(rng_state);
        steps = int'(rng_state % 4) + 1;
        base = pc_now;
        for (int k = 0; k < steps; k++) begin
            xfer(8'h05, b);
            pc_now = pc_now + 32'd4;
        end
        rng_state = xorshift(rng_state);
        pick = int'(rng_state % steps);
        old = base + 32'(4 * pick);
        idx = old[6:2];
        xfer(8'h07, b);
        xfer({3'b000, idx}, b);
        read_reply(4, v);
        check_value($sformatf("reg[%0d]", idx), (idx == 5'd0) ? 64'd0 : 64'(old), v);
        xfer(8'h07, b);
        xfer(8'h00, b);
        read_reply(4, v);
        check_value("reg[0]", 64'd0, v);
        get_pc(p1);
        check_value("pc", 64'(pc_now), 64'(p1));
        finish_test("register_read", err0);

        // fetch holds the pc before the last step
        err0 = errors;
        prev = pc_now - 32'd4;
        xfer(8'h09, b);
        read_reply(7, v);
        check_value("fetch", {8'h00, prev[23:0], ~prev}, v);
        finish_test("fetch_read", err0);

        err0 = errors;
        xfer(8'h03, b);
        get_pc(a);
        get_pc(c);
        checks++;
        assert (a != c) else begin
            $display("free run: the pc did not move between two reads (0x%0h)", a);
            errors++;
        end
        checks++;
        assert (a > 32'(`RESET_PC) && c > 32'(`RESET_PC) &&
                ((a - 32'(`RESET_PC)) % 4) == 0 && ((c - 32'(`RESET_PC)) % 4) == 0) else begin
            $display("free run: pc 0x%0h or 0x%0h is not a word step above reset", a, c);
            errors++;
        end
        finish_test("free_run", err0);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: common/core_pkg.sv
`include "soc_settings.svh"

package core_pkg;

    // one data word of the core
    typedef logic [`XLEN-1:0] xword_t;

    // index into the 32-entry register file
    typedef logic [4:0] reg_idx_t;

    typedef logic [`ALEN-1:0] addr_t;
    typedef logic [`ILEN-1:0] instr_t;

    // last fetch, address in the upper bits
    typedef struct packed {
        addr_t  addr;
        instr_t instr;
    } fetch_t;

endpackage

// File: common/dbg_pkg.sv
package dbg_pkg;

    // command byte sent by the host
    typedef enum logic [7:0] {
        CMD_NOP               = 8'h00,
        CMD_ECHO              = 8'h01,
        CMD_TOGGLE_LED        = 8'h02,
        CMD_ENABLE_CLOCK      = 8'h03,
        CMD_DISABLE_CLOCK     = 8'h04,
        CMD_STEP_CLOCK        = 8'h05,
        CMD_GET_PC            = 8'h06,
        CMD_GET_REG           = 8'h07,
        CMD_READ_FLASH        = 8'h08,
        CMD_GET_FETCHED_INSTR = 8'h09,
        CMD_ECHO_CC           = 8'hCC
    } dbg_cmd_e;

    // controller FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ECHO,
        ST_READ_REG,
        ST_REPLYING
    } dbg_state_e;

    // plain answers for commands without a payload
    localparam logic [7:0] ANSWER_NONE = 8'h00;
    localparam logic [7:0] ANSWER_CC   = 8'hCC;

    // flash busy or unknown command
    localparam logic [7:0] ANSWER_ERR  = 8'hFF;

endpackage

// File: common/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// core data, fetch address and instruction widths
`define XLEN 32
`define ALEN 24
`define ILEN 32

// first fetch address after reset
`define RESET_PC 'h000100

// reply lengths in bytes
`define WORD_REPLY_BYTES (`XLEN / 8)
`define FETCH_REPLY_BYTES ((`ALEN + `ILEN) / 8)

`endif

// File: core/step_core.sv
`timescale 1ns/10ps
`include "soc_settings.svh"

module step_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               core_en,
    output core_pkg::xword_t   pc,
    output core_pkg::fetch_t   fetch,
    input  core_pkg::reg_idx_t reg_sel,
    output core_pkg::xword_t   reg_data
);

    import core_pkg::*;

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    xword_t   regs [NREGS];
    reg_idx_t wr_idx;

    // target register follows the word address of the current pc
    assign wr_idx = pc[6:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= `XLEN'(`RESET_PC);
            fetch <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (core_en) begin
            pc <= pc + `XLEN'(4);
            // x0 stays hard-wired to zero
            if (wr_idx != '0) begin
                regs[wr_idx] <= pc;
            end
            fetch.addr  <= pc[`ALEN-1:0];
            fetch.instr <= ~pc[`ILEN-1:0];
        end
    end

    // debug read port
    assign reg_data = regs[reg_sel];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst) (reg_sel == '0) |-> (reg_data == '0)
    ) else $error("register 0 reads nonzero");

endmodule

// File: debug/core_clock_ctrl.sv
`timescale 1ns/10ps

module core_clock_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic step_toggle,
    output logic core_en
);

    logic step_prev;
    logic step_seen;

    // any flip of the toggle asks for one step
    assign step_seen = step_toggle ^ step_prev;

    // core runs after reset until the host halts it
    always_ff @(posedge clk) begin
        if (rst) begin
            core_en   <= 1'b1;
            step_prev <= 1'b0;
        end else begin
            core_en   <= run | step_seen;
            step_prev <= step_toggle;
        end
    end

endmodule

// File: debug/dbg_controller.sv
`timescale 1ns/10ps
`include "soc_settings.svh"

module dbg_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         recv_data,
    input  logic               recv_ready,
    output logic [7:0]         send_data,
    output core_pkg::reg_idx_t reg_sel,
    input  core_pkg::xword_t   pc,
    input  core_pkg::fetch_t   fetch,
    input  core_pkg::xword_t   reg_data,
    output logic               run,
    output logic               step_toggle,
    output logic               led
);

    import dbg_pkg::*;

    // reply buffer is sized for the longest reply
    localparam int REPLY_BITS = `FETCH_REPLY_BYTES * 8;
    localparam int WORD_PAD   = REPLY_BITS - `XLEN;
    localparam int CNT_W      = $clog2(`FETCH_REPLY_BYTES + 1);

    localparam logic [CNT_W-1:0] WORD_REST  = CNT_W'(`WORD_REPLY_BYTES - 1);
    localparam logic [CNT_W-1:0] FETCH_REST = CNT_W'(`FETCH_REPLY_BYTES - 1);

    dbg_state_e            state;
    dbg_cmd_e              cmd;
    logic [REPLY_BITS-1:0] reply_buf;
    logic [CNT_W-1:0]      reply_cnt;

    // replies left-aligned so the top byte always goes out next
    logic [REPLY_BITS-1:0] pc_word;
    logic [REPLY_BITS-1:0] reg_word;
    logic [REPLY_BITS-1:0] fetch_word;

    assign cmd        = dbg_cmd_e'(recv_data);
    assign reg_sel    = recv_data[4:0];
    assign pc_word    = {pc, {WORD_PAD{1'b0}}};
    assign reg_word   = {reg_data, {WORD_PAD{1'b0}}};
    assign fetch_word = fetch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            send_data   <= '0;
            reply_cnt   <= '0;
            run         <= 1'b1;
            step_toggle <= 1'b0;
            led         <= 1'b0;
        end else if (recv_ready) begin
            case (state)
                ST_IDLE: begin
                    case (cmd)
                        CMD_NOP: begin
                            send_data <= ANSWER_NONE;
                        end
                        CMD_ECHO: begin
                            send_data <= CMD_ECHO;
                            state     <= ST_ECHO;
                        end
                        CMD_TOGGLE_LED: begin
                            send_data <= ANSWER_NONE;
                            led       <= ~led;
                        end
                        CMD_ENABLE_CLOCK: begin
                            send_data <= ANSWER_NONE;
                            run       <= 1'b1;
                        end
                        CMD_DISABLE_CLOCK: begin
                            send_data <= ANSWER_NONE;
                            run       <= 1'b0;
                        end
                        CMD_STEP_CLOCK: begin
                            send_data   <= ANSWER_NONE;
                            step_toggle <= ~step_toggle;
                        end
                        CMD_GET_PC: begin
                            // first byte answers the command itself
                            send_data <= pc_word[REPLY_BITS-1 -: 8];
                            reply_buf <= pc_word << 8;
                            reply_cnt <= WORD_REST;
                            state     <= ST_REPLYING;
                        end
                        CMD_GET_REG: begin
                            send_data <= ANSWER_NONE;
                            state     <= ST_READ_REG;
                        end
                        CMD_GET_FETCHED_INSTR: begin
                            send_data <= fetch_word[REPLY_BITS-1 -: 8];
                            reply_buf <= fetch_word << 8;
                            reply_cnt <= FETCH_REST;
                            state     <= ST_REPLYING;
                        end
                        CMD_ECHO_CC: begin
                            send_data <= ANSWER_CC;
                        end
                        // flash belongs to the core
                        CMD_READ_FLASH: begin
                            send_data <= ANSWER_ERR;
                        end
                        default: begin
                            send_data <= ANSWER_ERR;
                        end
                    endcase
                end
                ST_ECHO: begin
                    send_data <= recv_data;
                    state     <= ST_IDLE;
                end
                ST_READ_REG: begin
                    // this byte is the register index
                    send_data <= reg_word[REPLY_BITS-1 -: 8];
                    reply_buf <= reg_word << 8;
                    reply_cnt <= WORD_REST;
                    state     <= ST_REPLYING;
                end
                ST_REPLYING: begin
                    send_data <= reply_buf[REPLY_BITS-1 -: 8];
                    reply_buf <= reply_buf << 8;
                    reply_cnt <= reply_cnt - 1'b1;
                    if (reply_cnt == CNT_W'(1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_reply_cnt: assert property (
        @(posedge clk) disable iff (rst) (state == ST_REPLYING) |-> (reply_cnt != '0)
    ) else $error("reply count empty while replying");

endmodule

// File: debug/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss,
    output logic       miso,
    input  logic [7:0] send_data,
    output logic [7:0] recv_data,
    output logic       recv_ready
);

    // two-stage synchronizers with bit 1 as the usable output
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;
    logic       sclk_prev;

    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    logic       selected;
    logic       sclk_rise;
    logic       sclk_fall;

    assign selected  = ~ss_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= '0;
            ss_sync   <= '1;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            ss_sync   <= {ss_sync[0], ss};
            sclk_prev <= sclk_sync[1];
        end
    end

    // mosi synchronizer
    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], mosi};
    end

    // receive side shifts MSB first on rising edges
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            recv_data  <= '0;
            recv_ready <= 1'b0;
        end else begin
            recv_ready <= 1'b0;
            if (!selected) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    recv_data  <= {rx_shift[6:0], mosi_sync[1]};
                    recv_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (selected && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
        end
    end

    // transmit byte latched on the first rising edge and shifted on falling edges
    always_ff @(posedge clk) begin
        if (selected && sclk_rise && bit_cnt == 3'd0) begin
            tx_shift <= send_data;
        end else if (selected && sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    // MSB has to sit on the line before the first rising edge
    assign miso = selected ? ((bit_cnt == 3'd0) ? send_data[7] : tx_shift[7]) : 1'b0;

    a_single_ready: assert property (
        @(posedge clk) disable iff (rst) recv_ready |=> !recv_ready
    ) else $error("recv_ready held for two cycles");

endmodule

// File: design/spi_soc.sv
`timescale 1ns/10ps

module spi_soc (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic ss,
    output logic miso,
    output logic led
);

    import core_pkg::*;

    // SPI byte link
    logic [7:0] recv_data;
    logic       recv_ready;
    logic [7:0] send_data;

    // debug access to the core
    reg_idx_t reg_sel;
    xword_t   reg_data;
    xword_t   pc;
    fetch_t   fetch;

    // core run control
    logic run;
    logic step_toggle;
    logic core_en;

    spi_slave u_spi (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .miso       (miso),
        .send_data  (send_data),
        .recv_data  (recv_data),
        .recv_ready (recv_ready)
    );

    dbg_controller u_dbg (
        .clk         (clk),
        .rst         (rst),
        .recv_data   (recv_data),
        .recv_ready  (recv_ready),
        .send_data   (send_data),
        .reg_sel     (reg_sel),
        .pc          (pc),
        .fetch       (fetch),
        .reg_data    (reg_data),
        .run         (run),
        .step_toggle (step_toggle),
        .led         (led)
    );

    core_clock_ctrl u_clk_ctrl (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .step_toggle (step_toggle),
        .core_en     (core_en)
    );

    step_core u_core (
        .clk      (clk),
        .rst      (rst),
        .core_en  (core_en),
        .pc       (pc),
        .fetch    (fetch),
        .reg_sel  (reg_sel),
        .reg_data (reg_data)
    );

endmodule

// File: spi_soc.f
+incdir+common
common/core_pkg.sv
common/dbg_pkg.sv
debug/spi_slave.sv
debug/dbg_controller.sv
debug/core_clock_ctrl.sv
core/step_core.sv
design/spi_soc.sv
bench/tb_spi_soc.sv
